//--- Bender.yml
package:
  name: lockstep_checker

dependencies: {}

sources:
  # Design
  - files:
      - hw/lockstep_pkg.sv
      - hw/sum_core.sv
      - hw/shadow_reset_gen.sv
      - hw/delay_line.sv
      - hw/mismatch_checker.sv
      - hw/lockstep_top.sv

  # Testbench
  - target: test
    files:
      - testbench/tb_lockstep.sv

export_include_dirs: []

# Simulation top is tb_lockstep, design top is lockstep_top

//--- hw/delay_line.sv
// Resettable shift register of DEPTH stages over a generic payload type
`timescale 1ns/1ps

module delay_line #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 1
) (
  input  logic     clk_i,
  input  logic     rst_ni,

  input  payload_t data_i,
  output payload_t data_o
);

  // Stage 0 is the newest entry
  payload_t stage_q [DEPTH];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < DEPTH; i++) begin
        stage_q[i] <= payload_t'('0);
      end
    end else begin
      stage_q[0] <= data_i;
      for (int unsigned i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // Oldest entry, DEPTH cycles behind data_i
  assign data_o = stage_q[DEPTH-1];

endmodule

//--- hw/lockstep_pkg.sv
// Lockstep widths, block length, lockstep offsets and core port structs
package lockstep_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath sizes
  ////////////////////////////////////////////////////////////////////////////

  // Input word width
  localparam int unsigned DATA_W = 16;

  // Block sum width, word width plus headroom for four additions
  localparam int unsigned SUM_W = 20;

  // Words summed per block
  localparam int unsigned BLOCK_LEN = 4;

  // Word counter inside a block
  localparam int unsigned CNT_W = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Lockstep timing
  ////////////////////////////////////////////////////////////////////////////

  // Cycles the shadow core lags behind the main core
  localparam int unsigned LOCKSTEP_OFFSET = 2;

  // Main outputs wait one extra cycle for the shadow output register
  localparam int unsigned OUTPUTS_OFFSET = LOCKSTEP_OFFSET + 1;

  // Reset sequencer counter
  localparam int unsigned OFFSET_W = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Core ports
  ////////////////////////////////////////////////////////////////////////////

  // Everything the environment drives into a core
  typedef struct packed {
    logic              in_valid;
    logic [DATA_W-1:0] in_data;
    logic              out_ready;
  } core_in_t;

  // Everything a core drives back out
  typedef struct packed {
    logic             in_ready;
    logic             out_valid;
    logic [SUM_W-1:0] out_sum;
    logic             busy;
  } core_out_t;

endpackage

//--- hw/lockstep_top.sv
// Lockstep checker top with delay lines, shadow core, reset sequencer and compare
`timescale 1ns/1ps

module lockstep_top import lockstep_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // Main core port traffic, observed only
  input  core_in_t  core_in_i,
  input  core_out_t core_out_i,

  output logic      alert_major_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Reset sequencing
  ////////////////////////////////////////////////////////////////////////////

  logic shadow_rst_n;
  logic cmp_en;

  shadow_reset_gen u_shadow_rst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_n),
    .cmp_en_o      (cmp_en)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Input delay
  ////////////////////////////////////////////////////////////////////////////

  core_in_t shadow_in;

  // Shadow core sees the main inputs LOCKSTEP_OFFSET cycles late
  delay_line #(
    .payload_t (core_in_t),
    .DEPTH     (LOCKSTEP_OFFSET)
  ) u_in_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (core_in_i),
    .data_o (shadow_in)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Output delay
  ////////////////////////////////////////////////////////////////////////////

  core_out_t main_out_dly;

  // One more stage than the inputs to match the shadow output register
  delay_line #(
    .payload_t (core_out_t),
    .DEPTH     (OUTPUTS_OFFSET)
  ) u_out_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (core_out_i),
    .data_o (main_out_dly)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Shadow core
  ////////////////////////////////////////////////////////////////////////////

  core_out_t shadow_out;

  sum_core u_shadow_core (
    .clk_i  (clk_i),
    .rst_ni (shadow_rst_n),
    .core_i (shadow_in),
    .core_o (shadow_out)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Output compare
  ////////////////////////////////////////////////////////////////////////////

  mismatch_checker u_checker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cmp_en_i   (cmp_en),
    .shadow_i   (shadow_out),
    .main_i     (main_out_dly),
    .mismatch_o (alert_major_o)
  );

endmodule

//--- hw/mismatch_checker.sv
// Shadow output register and compare against the delayed main core outputs
`timescale 1ns/1ps

module mismatch_checker import lockstep_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  input  logic      cmp_en_i,
  input  core_out_t shadow_i,
  input  core_out_t main_i,

  output logic      mismatch_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Shadow output register
  ////////////////////////////////////////////////////////////////////////////

  core_out_t shadow_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_q <= core_out_t'('0);
    end else begin
      shadow_q <= shadow_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare
  ////////////////////////////////////////////////////////////////////////////

  logic differ;

  // Any field counts, including handshake and busy
  assign differ     = (shadow_q != main_i);
  assign mismatch_o = cmp_en_i & differ;

endmodule

//--- hw/shadow_reset_gen.sv
// Shadow core reset release and comparison enable sequencer
`timescale 1ns/1ps

module shadow_reset_gen import lockstep_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,

  output logic shadow_rst_no,
  output logic cmp_en_o
);

  logic [OFFSET_W-1:0] cnt_q;
  logic [OFFSET_W-1:0] cnt_d;
  logic                set_d;
  logic                set_q;
  logic                cmp_en_q;

  // Count to LOCKSTEP_OFFSET - 1 and stay there
  assign set_d = (cnt_q == OFFSET_W'(LOCKSTEP_OFFSET - 1));
  assign cnt_d = set_d ? cnt_q : cnt_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      set_q    <= 1'b0;
      cmp_en_q <= 1'b0;
    end else begin
      cnt_q    <= cnt_d;
      set_q    <= set_d;
      // Compare one cycle after the shadow core leaves reset
      cmp_en_q <= set_q;
    end
  end

  assign shadow_rst_no = set_q;
  assign cmp_en_o      = cmp_en_q;

endmodule

//--- hw/sum_core.sv
// Block-sum core, adds words in blocks of BLOCK_LEN over valid/ready streams
`timescale 1ns/1ps

module sum_core import lockstep_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  input  core_in_t  core_i,
  output core_out_t core_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////////////////////

  logic [CNT_W-1:0] cnt_q;
  logic [SUM_W-1:0] acc_q;
  logic [SUM_W-1:0] sum_q;
  logic             out_valid_q;

  logic             in_ready;
  logic             in_fire;
  logic             out_fire;
  logic             last_word;
  logic [SUM_W-1:0] acc_next;

  // No new words while a finished sum waits to be taken
  assign in_ready  = ~out_valid_q;
  assign in_fire   = core_i.in_valid & in_ready;
  assign out_fire  = out_valid_q & core_i.out_ready;

  assign last_word = (cnt_q == CNT_W'(BLOCK_LEN - 1));
  assign acc_next  = acc_q + SUM_W'(core_i.in_data);

  ////////////////////////////////////////////////////////////////////////////
  // Accumulator and word counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      acc_q <= '0;
    end else if (in_fire) begin
      if (last_word) begin
        // Block complete, start the next one from zero
        cnt_q <= '0;
        acc_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
        acc_q <= acc_next;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sum_q       <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (in_fire && last_word) begin
        sum_q       <= acc_next;
        out_valid_q <= 1'b1;
      end else if (out_fire) begin
        // Sum value stays put, only valid drops
        out_valid_q <= 1'b0;
      end
    end
  end

  // Busy while a block is partly accepted or a sum is pending
  assign core_o.in_ready  = in_ready;
  assign core_o.out_valid = out_valid_q;
  assign core_o.out_sum   = sum_q;
  assign core_o.busy      = (cnt_q != '0) | out_valid_q;

endmodule

//--- project.f
hw/lockstep_pkg.sv
hw/sum_core.sv
hw/shadow_reset_gen.sv
hw/delay_line.sv
hw/mismatch_checker.sv
hw/lockstep_top.sv
testbench/tb_lockstep.sv

//--- testbench/tb_lockstep.sv
// Lockstep testbench with main core, random traffic, fault injection, alert and sum checks
`timescale 1ns/1ps

module tb_lockstep import lockstep_pkg::*; ();

  localparam int unsigned CLK_PERIOD    = 20;
  localparam int unsigned RST_CYCLES    = 4;
  localparam int unsigned CLEAN_CYCLES  = 300;
  localparam int unsigned STALL_CYCLES  = 300;
  localparam int unsigned N_SUM_FLIPS   = 8;
  localparam int unsigned N_FIELD_FLIPS = 6;
  localparam int unsigned WAIT_MAX      = 40;
  localparam int unsigned GAP_CYCLES    = 8;
  localparam int unsigned POST_CYCLES   = 100;
  localparam int unsigned TEST_CYCLES   = 2 * (RST_CYCLES + 1) + CLEAN_CYCLES + STALL_CYCLES
      + N_SUM_FLIPS * (WAIT_MAX + GAP_CYCLES + 2) + N_FIELD_FLIPS * (GAP_CYCLES + 1)
      + OUTPUTS_OFFSET + 1 + POST_CYCLES + GAP_CYCLES;
  localparam int unsigned WATCHDOG_NS   = TEST_CYCLES * CLK_PERIOD + 2000;
  localparam int unsigned OUT_W         = $bits(core_out_t);

  logic        clk_i = 1'b0;
  logic        rst_ni;
  core_in_t    core_in;
  core_out_t   main_out;
  core_out_t   fault_mask;
  core_out_t   core_out;
  logic        alert_major;
  integer      seed;
  int          ready_level;

  int unsigned alert_cnt  = 0;
  int unsigned exp_alerts = 0;
  int unsigned sums_taken = 0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Main core and DUT
  ////////////////////////////////////////////////////////////////////////////

  sum_core main_core (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .core_i (core_in),
    .core_o (main_out)
  );

  // Faults only corrupt what the checker observes
  assign core_out = main_out ^ fault_mask;

  lockstep_top dut0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .core_in_i     (core_in),
    .core_out_i    (core_out),
    .alert_major_o (alert_major)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Alert prediction
  ////////////////////////////////////////////////////////////////////////////

  logic [OUTPUTS_OFFSET-1:0] fault_hist_q = '0;
  int unsigned               since_rel_q  = 0;
  logic                      alert_exp;

  // A faulty cycle shows up OUTPUTS_OFFSET cycles later once compare is on
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fault_hist_q <= '0;
      since_rel_q  <= 0;
    end else begin
      fault_hist_q <= {fault_hist_q[OUTPUTS_OFFSET-2:0], (fault_mask != '0)};
      if (since_rel_q < OUTPUTS_OFFSET) begin
        since_rel_q <= since_rel_q + 1;
      end
    end
  end

  assign alert_exp = fault_hist_q[OUTPUTS_OFFSET-1] && (since_rel_q >= OUTPUTS_OFFSET);

  always @(posedge clk_i) begin
    if (alert_major) begin
      alert_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Block sum model
  ////////////////////////////////////////////////////////////////////////////

  logic [SUM_W-1:0] acc_m;
  int unsigned      words_m;
  logic [SUM_W-1:0] sum_fifo[$];
  logic [SUM_W-1:0] exp_sum;
  logic             hold_pend;
  logic [SUM_W-1:0] held_sum;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_m     = '0;
      words_m   = 0;
      hold_pend = 1'b0;
      sum_fifo.delete();
    end else begin
      if (hold_pend) begin
        assert (main_out.out_sum == held_sum)
          else stop_on_error($sformatf("FAIL out_sum got %h expected %h",
                                       main_out.out_sum, held_sum));
      end
      if (main_out.out_valid && core_in.out_ready) begin
        assert (sum_fifo.size() > 0)
          else stop_on_error("a sum was taken before any block was complete");
        exp_sum = sum_fifo.pop_front();
        assert (main_out.out_sum == exp_sum)
          else stop_on_error($sformatf("FAIL out_sum got %h expected %h",
                                       main_out.out_sum, exp_sum));
        sums_taken++;
      end
      if (core_in.in_valid && main_out.in_ready) begin
        acc_m = acc_m + SUM_W'(core_in.in_data);
        words_m++;
        if (words_m == BLOCK_LEN) begin
          sum_fifo.push_back(acc_m);
          acc_m   = '0;
          words_m = 0;
        end
      end
      hold_pend = main_out.out_valid && !core_in.out_ready;
      held_sum  = main_out.out_sum;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  a_alert: assert property (@(negedge clk_i) alert_major == alert_exp)
    else stop_on_error($sformatf("FAIL alert_major_o got %h expected %h",
                                 $sampled(alert_major), $sampled(alert_exp)));

  a_no_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
      main_out.out_valid |-> !main_out.in_ready)
    else stop_on_error("in_ready was high while a sum was waiting");

  a_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (main_out.out_valid && !core_in.out_ready) |=> main_out.out_valid)
    else stop_on_error("out_valid dropped before the sum was taken");

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_inputs();
    core_in.in_valid  = (($random(seed) & 7) != 0);
    core_in.in_data   = DATA_W'($random(seed));
    core_in.out_ready = (($random(seed) & 7) < ready_level);
  endtask

  function automatic core_out_t random_mask();
    logic [OUT_W-1:0] bits;
    bits = OUT_W'($random(seed));
    if (bits == '0) begin
      bits[0] = 1'b1;
    end
    return core_out_t'(bits);
  endfunction

  task automatic step(input core_out_t m);
    @(negedge clk_i);
    drive_inputs();
    fault_mask = m;
  endtask

  task automatic idle(input int unsigned n);
    for (int unsigned k = 0; k < n; k++) begin
      step('0);
    end
  endtask

  // Reset is already low here, faults keep flowing while it is held
  task automatic hold_reset();
    for (int unsigned k = 1; k < RST_CYCLES; k++) begin
      @(negedge clk_i);
      drive_inputs();
      fault_mask = random_mask();
    end
    @(negedge clk_i);
    drive_inputs();
    fault_mask = '0;
    rst_ni     = 1'b1;
  endtask

  task automatic flip_on_valid(input core_out_t m);
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (!main_out.out_valid) begin
      drive_inputs();
      fault_mask = '0;
      n++;
      if (n > WAIT_MAX) begin
        stop_on_error("out_valid never rose for the out_sum fault");
      end
      @(negedge clk_i);
    end
    drive_inputs();
    fault_mask = m;
  endtask

  initial begin
    core_out_t m;
    seed        = 67;
    ready_level = 7;
    rst_ni      = 1'b0;
    core_in     = '0;
    fault_mask  = random_mask();
    hold_reset();

    // Clean traffic, few stalls
    idle(CLEAN_CYCLES);

    // Heavy back-pressure
    ready_level = 2;
    idle(STALL_CYCLES);

    ready_level = 5;
    for (int unsigned i = 0; i < N_SUM_FLIPS; i++) begin
      m = '0;
      m.out_sum[unsigned'($random(seed)) % SUM_W] = 1'b1;
      flip_on_valid(m);
      exp_alerts++;
      idle(GAP_CYCLES);
    end

    for (int unsigned i = 0; i < N_FIELD_FLIPS; i++) begin
      m = '0;
      case (i % 3)
        0:       m.in_ready  = 1'b1;
        1:       m.out_valid = 1'b1;
        default: m.busy      = 1'b1;
      endcase
      step(m);
      exp_alerts++;
      idle(GAP_CYCLES);
    end

    // Mid-run reset while an alert is up
    m      = '0;
    m.busy = 1'b1;
    step(m);
    idle(OUTPUTS_OFFSET - 1);
    @(negedge clk_i);
    assert (alert_major == 1'b1)
      else stop_on_error("alert did not rise before the mid-run reset");
    drive_inputs();
    fault_mask = random_mask();
    rst_ni     = 1'b0;
    #1;
    assert (alert_major == 1'b0)
      else stop_on_error("alert stayed high after reset was asserted");
    hold_reset();
    idle(POST_CYCLES);
    idle(GAP_CYCLES);

    assert (alert_cnt == exp_alerts)
      else stop_on_error($sformatf("FAIL alert_major_o pulses got %h expected %h",
                                   alert_cnt, exp_alerts));
    assert (sums_taken > 0)
      else stop_on_error("no block sums were taken from the main core");
    $display("Test OK");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    stop_on_error("watchdog expired before the tests finished");
  end

endmodule
